// ==== src/tex_pkg.sv ====
package tex_pkg;

  // index and size width, max 4096 texels per axis
  localparam int W_BITS    = 12;
  localparam int COORD_W   = 32;   // Q16.16
  localparam int FRAC_BITS = 16;
  localparam int RAM_AW    = 12;   // 4096 texel words
  localparam int TEXEL_W   = 32;

  typedef logic        [W_BITS-1:0]  tex_dim_t;   // width, height, x or y
  typedef logic signed [COORD_W-1:0] coord_t;     // normalized coordinate
  typedef logic        [TEXEL_W-1:0] texel_t;     // texel or colour
  typedef logic        [RAM_AW-1:0]  ram_addr_t;

  // per-axis addressing mode, encoding matches REG_MODE fields
  typedef enum logic [1:0] {
    CLAMP_EDGE   = 2'd0,
    REPEAT       = 2'd1,
    MIRROR       = 2'd2,
    CLAMP_BORDER = 2'd3
  } wrap_mode_e;

  typedef struct packed {
    tex_dim_t   width;
    tex_dim_t   height;
    wrap_mode_e mode_u;
    wrap_mode_e mode_v;
  } tex_cfg_t;

  typedef struct packed {
    coord_t u;
    coord_t v;
  } tex_req_t;

  typedef struct packed {
    texel_t texel;
    logic   border;    // sample fell outside a CLAMP_BORDER axis
  } tex_resp_t;

  // APB register offsets
  localparam logic [7:0] REG_SIZE   = 8'h00;
  localparam logic [7:0] REG_MODE   = 8'h04;
  localparam logic [7:0] REG_BORDER = 8'h08;
  localparam logic [7:0] REG_WADDR  = 8'h0C;
  localparam logic [7:0] REG_WDATA  = 8'h10;   // write-only window

endpackage

// ==== src/tex_regs.sv ====
`timescale 1ns/1ps

module tex_regs (
  input  logic               clk,
  input  logic               reset,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  logic [7:0]         paddr,
  input  logic [31:0]        pwdata,
  output logic [31:0]        prdata,
  output logic               pready,
  output logic               pslverr,
  output tex_pkg::tex_cfg_t  cfg,
  output tex_pkg::texel_t    border_color,
  output logic               wr_en,
  output tex_pkg::ram_addr_t wr_addr,
  output tex_pkg::texel_t    wr_data
);
  import tex_pkg::*;

  logic      wr_acc;    // write in access phase
  logic      rd_acc;    // read in access phase
  ram_addr_t wr_ptr;    // auto-incrementing texel pointer

  assign wr_acc = psel && penable && pwrite;
  assign rd_acc = psel && penable && !pwrite;

  // zero wait states, no error responses
  assign pready  = 1'b1;
  assign pslverr = 1'b0;

  always_ff @(posedge clk) begin
    if (reset) begin
      cfg.width    <= W_BITS'(1);
      cfg.height   <= W_BITS'(1);
      cfg.mode_u   <= CLAMP_EDGE;
      cfg.mode_v   <= CLAMP_EDGE;
      border_color <= '0;
      wr_ptr       <= '0;
    end else if (wr_acc) begin
      case (paddr)
        REG_SIZE: begin
          cfg.width  <= pwdata[W_BITS-1:0];
          cfg.height <= pwdata[16 +: W_BITS];
        end
        REG_MODE: begin
          cfg.mode_u <= wrap_mode_e'(pwdata[1:0]);
          cfg.mode_v <= wrap_mode_e'(pwdata[3:2]);
        end
        REG_BORDER: border_color <= pwdata;
        REG_WADDR:  wr_ptr <= pwdata[RAM_AW-1:0];
        REG_WDATA:  wr_ptr <= wr_ptr + ram_addr_t'(1);   // step after the texel write
        default: ;
      endcase
    end
  end

  // texel write goes out during the access cycle, one strobe per access
  assign wr_en   = wr_acc && (paddr == REG_WDATA);
  assign wr_addr = wr_ptr;
  assign wr_data = pwdata;

  // read mux, valid while the access phase lasts
  always_comb begin
    prdata = '0;
    if (rd_acc) begin
      case (paddr)
        REG_SIZE: begin
          prdata[W_BITS-1:0]   = cfg.width;
          prdata[16 +: W_BITS] = cfg.height;
        end
        REG_MODE:   prdata[3:0] = {cfg.mode_v, cfg.mode_u};
        REG_BORDER: prdata = border_color;
        REG_WADDR:  prdata[RAM_AW-1:0] = wr_ptr;
        default:    prdata = '0;   // REG_WDATA and holes read zero
      endcase
    end
  end

endmodule

// ==== src/tex_wrap_axis.sv ====
`timescale 1ns/1ps

module tex_wrap_axis (
  input  tex_pkg::coord_t     coord,
  input  tex_pkg::tex_dim_t   size,
  input  tex_pkg::wrap_mode_e mode,
  output tex_pkg::tex_dim_t   idx,
  output logic                border
);
  import tex_pkg::*;

  // coord * size needs one extra bit for the zero-extended size
  localparam int PROD_W = COORD_W + W_BITS + 1;
  localparam int S_W    = PROD_W - FRAC_BITS;   // floored integer part

  logic signed [PROD_W-1:0] prod;
  logic signed [S_W-1:0]    s;        // floor(coord * size)
  logic        [S_W-1:0]    size_u;
  logic        [S_W-1:0]    size2;    // mirror period
  logic        [S_W-1:0]    mag;      // |s|
  logic        [S_W-1:0]    rem_n;
  logic        [S_W-1:0]    rem_2n;
  logic        [S_W-1:0]    rep_idx;
  logic        [S_W-1:0]    mir_p;
  logic        [S_W-1:0]    mir_idx;
  logic                     neg;
  logic                     over;     // s >= size

  assign prod = PROD_W'(coord) * PROD_W'($signed({1'b0, size}));
  assign s    = S_W'(prod >>> FRAC_BITS);   // arithmetic shift floors negatives too

  assign size_u = S_W'(size);
  assign size2  = S_W'({size, 1'b0});

  assign neg  = s[S_W-1];
  assign over = !neg && (s[S_W-1:0] >= size_u);
  assign mag  = neg ? -s : s;

  // magnitude remainders, folded back for negative s
  assign rem_n  = mag % size_u;
  assign rem_2n = mag % size2;

  assign rep_idx = (neg && rem_n != '0) ? size_u - rem_n : rem_n;

  // p in [0, 2N), second half reflected
  assign mir_p   = (neg && rem_2n != '0) ? size2 - rem_2n : rem_2n;
  assign mir_idx = (mir_p < size_u) ? mir_p : size2 - mir_p - S_W'(1);

  always_comb begin
    border = 1'b0;
    case (mode)
      CLAMP_EDGE: begin
        if (neg)       idx = '0;
        else if (over) idx = size - W_BITS'(1);   // last texel
        else           idx = s[W_BITS-1:0];
      end
      REPEAT: idx = rep_idx[W_BITS-1:0];
      MIRROR: idx = mir_idx[W_BITS-1:0];
      CLAMP_BORDER: begin
        if (neg || over) begin
          idx    = '0;
          border = 1'b1;   // caller swaps in the border colour
        end else begin
          idx = s[W_BITS-1:0];
        end
      end
      default: idx = '0;
    endcase
  end

endmodule

// ==== src/tex_addr_gen.sv ====
`timescale 1ns/1ps

module tex_addr_gen (
  input  logic              clk,
  input  logic              reset,
  input  logic              req_valid,
  output logic              req_ready,
  input  tex_pkg::tex_req_t req,
  input  logic              stall,
  input  tex_pkg::tex_cfg_t cfg,
  output logic              s1_valid,
  output tex_pkg::tex_dim_t s1_x,
  output tex_pkg::tex_dim_t s1_y,
  output logic              s1_border
);
  import tex_pkg::*;

  tex_dim_t idx_u;
  tex_dim_t idx_v;
  logic     border_u;
  logic     border_v;

  // u against width
  tex_wrap_axis i_wrap_u (
    .coord  (req.u),
    .size   (cfg.width),
    .mode   (cfg.mode_u),
    .idx    (idx_u),
    .border (border_u)
  );

  // v against height
  tex_wrap_axis i_wrap_v (
    .coord  (req.v),
    .size   (cfg.height),
    .mode   (cfg.mode_v),
    .idx    (idx_v),
    .border (border_v)
  );

  // whole pipe advances together, so a free output means a free input
  assign req_ready = !stall;

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
    end else if (!stall) begin
      s1_valid <= req_valid;   // bubble when nothing offered
    end
  end

  // stage payload, only loaded on an accepted request
  always_ff @(posedge clk) begin
    if (!stall && req_valid) begin
      s1_x      <= idx_u;
      s1_y      <= idx_v;
      s1_border <= border_u | border_v;   // either axis out of range
    end
  end

endmodule

// ==== src/texel_ram.sv ====
`timescale 1ns/1ps

module texel_ram (
  input  logic               clk,
  input  logic               wr_en,
  input  tex_pkg::ram_addr_t wr_addr,
  input  tex_pkg::texel_t    wr_data,
  input  logic               rd_en,
  input  tex_pkg::ram_addr_t rd_addr,
  output tex_pkg::texel_t    rd_data
);
  import tex_pkg::*;

  localparam int DEPTH = 1 << RAM_AW;

  texel_t mem [0:DEPTH-1];

  // APB loading port
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // registered read, holds its word while rd_en is low
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];   // old data on same-address write
    end
  end

endmodule

// ==== src/texel_fetch.sv ====
`timescale 1ns/1ps

module texel_fetch (
  input  logic               clk,
  input  logic               reset,
  input  logic               s1_valid,
  input  tex_pkg::tex_dim_t  s1_x,
  input  tex_pkg::tex_dim_t  s1_y,
  input  logic               s1_border,
  input  tex_pkg::tex_cfg_t  cfg,
  input  tex_pkg::texel_t    border_color,
  output logic               rd_en,
  output tex_pkg::ram_addr_t rd_addr,
  input  tex_pkg::texel_t    rd_data,
  output logic               stall,
  output logic               resp_valid,
  input  logic               resp_ready,
  output tex_pkg::tex_resp_t resp
);
  import tex_pkg::*;

  logic border_q;   // travels with the memory read

  // held response blocks everything upstream
  assign stall = resp_valid && !resp_ready;

  // y * width + x, modulo memory depth
  assign rd_addr = ram_addr_t'(s1_y) * ram_addr_t'(cfg.width) + ram_addr_t'(s1_x);

  // ram output register doubles as the stage register
  assign rd_en = s1_valid && !stall;

  always_ff @(posedge clk) begin
    if (reset) begin
      resp_valid <= 1'b0;
    end else if (!stall) begin
      resp_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      border_q <= s1_border;
    end
  end

  // border colour replaces the fetched word
  assign resp.texel  = border_q ? border_color : rd_data;
  assign resp.border = border_q;

endmodule

// ==== src/tex_sampler.sv ====
`timescale 1ns/1ps

module tex_sampler (
  input  logic               clk,
  input  logic               reset,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  logic [7:0]         paddr,
  input  logic [31:0]        pwdata,
  output logic [31:0]        prdata,
  output logic               pready,
  output logic               pslverr,
  input  logic               req_valid,
  output logic               req_ready,
  input  tex_pkg::tex_req_t  req,
  output logic               resp_valid,
  input  logic               resp_ready,
  output tex_pkg::tex_resp_t resp
);
  import tex_pkg::*;

  tex_cfg_t  cfg;
  texel_t    border_color;
  logic      wr_en;
  ram_addr_t wr_addr;
  texel_t    wr_data;
  logic      s1_valid;
  tex_dim_t  s1_x;
  tex_dim_t  s1_y;
  logic      s1_border;
  logic      rd_en;
  ram_addr_t rd_addr;
  texel_t    rd_data;
  logic      stall;   // from the output stage back to stage 1

  // config registers and texel load port
  tex_regs i_tex_regs (
    .clk, .reset,
    .psel, .penable, .pwrite, .paddr, .pwdata,
    .prdata, .pready, .pslverr,
    .cfg, .border_color,
    .wr_en, .wr_addr, .wr_data
  );

  // stage 1, scale and wrap
  tex_addr_gen i_tex_addr_gen (
    .clk, .reset,
    .req_valid, .req_ready, .req,
    .stall, .cfg,
    .s1_valid, .s1_x, .s1_y, .s1_border
  );

  texel_ram i_texel_ram (
    .clk,
    .wr_en, .wr_addr, .wr_data,
    .rd_en, .rd_addr, .rd_data
  );

  // stage 2, address, read and border select
  texel_fetch i_texel_fetch (
    .clk, .reset,
    .s1_valid, .s1_x, .s1_y, .s1_border,
    .cfg, .border_color,
    .rd_en, .rd_addr, .rd_data,
    .stall, .resp_valid, .resp_ready, .resp
  );

endmodule

// ==== tb/tex_sampler_asserts.sv ====
`timescale 1ns/1ps

module tex_sampler_asserts (
  input logic               clk,
  input logic               reset,
  input logic               req_valid,
  input logic               req_ready,
  input logic               resp_valid,
  input logic               resp_ready,
  input tex_pkg::tex_resp_t resp,
  input logic               s1_valid,
  input logic               pslverr
);
  import tex_pkg::*;

  int fail_count = 0;   // read by the testbench at the end

  // both stages empty right after reset
  reset_empty: assert property (@(posedge clk) reset |=> !resp_valid && !s1_valid)
    else begin $error("pipeline not empty after reset"); fail_count++; end

  // two-cycle latency when the output is not stalled
  latency_two: assert property (@(posedge clk) disable iff (reset)
    $past(req_valid && req_ready, 2) && $past(resp_ready) |-> resp_valid)
    else begin $error("response missing two cycles after request"); fail_count++; end

  // held response keeps valid and data
  stall_hold: assert property (@(posedge clk) disable iff (reset)
    resp_valid && !resp_ready |=> resp_valid && $stable(resp))
    else begin $error("response changed while stalled"); fail_count++; end

  ready_rule: assert property (@(posedge clk) disable iff (reset)
    req_ready == !(resp_valid && !resp_ready))
    else begin $error("req_ready does not follow the stall"); fail_count++; end

  no_slverr: assert property (@(posedge clk) !pslverr)
    else begin $error("pslverr raised"); fail_count++; end

endmodule

// ==== tb/tb_tex_sampler.sv ====
`timescale 1ns/1ps

module tb_tex_sampler;
  import tex_pkg::*;

  localparam int TIMEOUT_CYCLES = 4000;     // roughly 2x the traffic below
  localparam int COORD_SPAN     = 196608;   // 3.0 in Q16.16

  logic        clk = 1'b0;
  logic        reset;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        req_valid;
  logic        req_ready;
  tex_req_t    req;
  logic        resp_valid;
  logic        resp_ready;
  tex_resp_t   resp;

  texel_t     mem_model [0:4095];   // mirror of the texel memory
  int         cur_w;
  int         cur_h;
  wrap_mode_e cur_mu;
  wrap_mode_e cur_mv;
  texel_t     cur_border;
  tex_resp_t  exp_q [$];            // predicted responses in order
  int         errors = 0;
  int         cycles = 0;

  tex_sampler i_tex_sampler (
    .clk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
    .req_valid, .req_ready, .req, .resp_valid, .resp_ready, .resp
  );

  bind tex_sampler tex_sampler_asserts i_asserts (
    .clk(clk), .reset(reset), .req_valid(req_valid), .req_ready(req_ready),
    .resp_valid(resp_valid), .resp_ready(resp_ready), .resp(resp),
    .s1_valid(s1_valid), .pslverr(pslverr)
  );

  always #50 clk = ~clk;

  // hard stop in case a response never shows up
  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Something failed");
      $finish;
    end
  end

  task automatic check_word(input logic [32:0] got, input logic [32:0] exp, input string what);
    assert (got === exp) else begin
      $display("FAIL %0d ns: %s, got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  // setup phase, access phase, then idle
  task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] data,
                            output logic [31:0] rdata);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = data;
    @(negedge clk);
    penable = 1'b1;
    #1 rdata = prdata;   // comb read data, stable until the edge
    check_word({32'h0, pready}, 33'h1, "pready in access phase");   // no wait states
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] ignored;
    apb_access(1'b1, addr, data, ignored);
  endtask

  task automatic read_expect(input logic [7:0] addr, input logic [31:0] exp, input string what);
    logic [31:0] rd;
    apb_access(1'b0, addr, 32'h0, rd);
    check_word({1'b0, rd}, {1'b0, exp}, what);
  endtask

  task automatic set_config(input int w, input int h, input wrap_mode_e mu, input wrap_mode_e mv,
                            input texel_t bc);
    apb_write(REG_SIZE, (32'(h) << 16) | 32'(w));
    apb_write(REG_MODE, 32'({mv, mu}));
    apb_write(REG_BORDER, bc);
    cur_w      = w;
    cur_h      = h;
    cur_mu     = mu;
    cur_mv     = mv;
    cur_border = bc;
  endtask

  // fill 0 .. w*h-1 through the write window
  task automatic load_texture(input int w, input int h);
    apb_write(REG_WADDR, 32'h0);
    for (int i = 0; i < w * h; i++) begin
      apb_write(REG_WDATA, 32'(i) ^ 32'ha5a5_0000);
      mem_model[i] = 32'(i) ^ 32'ha5a5_0000;
    end
  endtask

  // scale, floor, then wrap one axis
  function automatic int axis_index(input coord_t c, input longint n, input wrap_mode_e m,
                                    output bit out);
    longint s;
    longint r;
    s   = (longint'(c) * n) >>> FRAC_BITS;
    out = 1'b0;
    case (m)
      CLAMP_EDGE: r = (s < 0) ? 0 : ((s >= n) ? n - 1 : s);
      REPEAT: begin
        r = s % n;
        if (r < 0) r += n;   // true remainder
      end
      MIRROR: begin
        r = s % (2 * n);
        if (r < 0) r += 2 * n;
        if (r >= n) r = 2 * n - 1 - r;   // reflected half
      end
      default: begin
        out = (s < 0) || (s >= n);
        r   = out ? 0 : s;
      end
    endcase
    return int'(r);
  endfunction

  function automatic tex_resp_t predict(input tex_req_t rq);
    int        x;
    int        y;
    bit        bu;
    bit        bv;
    tex_resp_t p;
    x        = axis_index(rq.u, longint'(cur_w), cur_mu, bu);
    y        = axis_index(rq.v, longint'(cur_h), cur_mv, bv);
    p.border = bu | bv;
    p.texel  = p.border ? cur_border : mem_model[(y * cur_w + x) % 4096];
    return p;
  endfunction

  function automatic coord_t rand_coord();
    return coord_t'(int'($urandom_range(0, 2 * COORD_SPAN)) - COORD_SPAN);
  endfunction

  // n requests, optional random back-pressure and idle gaps
  task automatic run_stream(input int n, input bit bp);
    int        sent;
    bit        fired;
    tex_resp_t exp;
    sent  = 0;
    fired = 1'b0;
    while (sent < n || exp_q.size() != 0) begin
      @(negedge clk);
      if (fired) req_valid = 1'b0;
      resp_ready = bp ? ($urandom_range(0, 2) != 0) : 1'b1;
      if (!req_valid && sent < n && (!bp || $urandom_range(0, 3) != 0)) begin
        req.u     = rand_coord();
        req.v     = rand_coord();
        req_valid = 1'b1;
      end
      #1 fired = req_valid && req_ready;   // transfers at the next rising edge
      if (resp_valid && resp_ready) begin
        if (exp_q.size() == 0) begin
          $display("response arrived with no request outstanding at %0d ns", $time);
          errors++;
        end else begin
          exp = exp_q.pop_front();
          check_word(resp, exp, "texel response");
        end
      end
      if (fired) begin
        exp_q.push_back(predict(req));
        sent++;
      end
    end
    @(negedge clk);
    req_valid  = 1'b0;
    resp_ready = 1'b1;
  endtask

  initial begin
    void'($urandom(32'hc761_516f));
    reset      = 1'b1;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = 8'h0;
    pwdata     = 32'h0;
    req_valid  = 1'b0;
    req        = '0;
    resp_ready = 1'b1;
    repeat (5) @(posedge clk);
    @(negedge clk) reset = 1'b0;

    // register readback, write window reads zero
    apb_write(REG_SIZE, 32'h0008_0010);
    apb_write(REG_MODE, 32'h0000_0009);
    apb_write(REG_BORDER, 32'h1234_5678);
    apb_write(REG_WADDR, 32'h0000_0abc);
    read_expect(REG_SIZE, 32'h0008_0010, "REG_SIZE readback");
    read_expect(REG_MODE, 32'h0000_0009, "REG_MODE readback");
    read_expect(REG_BORDER, 32'h1234_5678, "REG_BORDER readback");
    read_expect(REG_WADDR, 32'h0000_0abc, "REG_WADDR readback");
    read_expect(REG_WDATA, 32'h0, "REG_WDATA read");

    // clamp and repeat on a 16x8 texture
    set_config(16, 8, CLAMP_EDGE, REPEAT, 32'h0);
    load_texture(16, 8);
    run_stream(40, 1'b0);
    set_config(16, 8, REPEAT, CLAMP_EDGE, 32'h0);
    run_stream(40, 1'b0);

    // mirror, u reaches +-15 against 2N = 10, v +-21 against 14
    set_config(5, 7, MIRROR, MIRROR, 32'h0);
    load_texture(5, 7);
    run_stream(60, 1'b0);

    // border on one axis at a time
    set_config(10, 6, CLAMP_BORDER, CLAMP_EDGE, 32'hc0ff_ee01);
    load_texture(10, 6);
    run_stream(60, 1'b0);
    set_config(10, 6, CLAMP_EDGE, CLAMP_BORDER, 32'h0bad_f00d);
    run_stream(60, 1'b0);

    // back-pressure, 16x8 words still in memory
    set_config(16, 8, MIRROR, CLAMP_BORDER, 32'h7777_0001);
    run_stream(200, 1'b1);

    repeat (3) @(negedge clk);
    $display("errors: %0d, assertion failures: %0d", errors,
             i_tex_sampler.i_asserts.fail_count);
    if (errors == 0 && i_tex_sampler.i_asserts.fail_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== tex_sampler.f ====
src/tex_pkg.sv
src/tex_regs.sv
src/tex_wrap_axis.sv
src/tex_addr_gen.sv
src/texel_ram.sv
src/texel_fetch.sv
src/tex_sampler.sv
tb/tex_sampler_asserts.sv
tb/tb_tex_sampler.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the tex_sampler testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f tex_sampler.f --top-module tb_tex_sampler \
  -o sim_tex_sampler
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

# raise the error limit so every failing assertion is reported
./obj_dir/sim_tex_sampler +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Everything OK$" "$LOG"; then
  exit 0
fi
exit 1
